/* build.f */
+incdir+hdl
hdl/noc_pkg.sv
hdl/pe_pkg.sv
hdl/flit_fifo.sv
hdl/xy_router.sv
hdl/ddma.sv
hdl/tcd_mmio.sv
hdl/dual_port_ram.sv
hdl/manycore_pe.sv
bench/manycore_pe_properties.sv
bench/manycore_pe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= manycore_pe_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/manycore_pe_tb.sv */
`default_nettype none
`include "pe_cfg.svh"

module manycore_pe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import noc_pkg::*;
  import pe_pkg::*;

  localparam node_t SELF    = '{x: 4'd1, y: 4'd1};
  localparam int    TIMEOUT = 2000;   // cycles per wait

  logic                     clock;
  logic                     rst_n;
  link_t [3:0]              link_in;
  link_t [3:0]              link_out;
  logic [3:0]               credit_in;
  logic [3:0]               credit_out;
  mmio_req_t                mmio;
  logic [`MEMORY_WIDTH-1:0] mmio_rdata;
  logic                     irq;

  logic [`MEMORY_WIDTH-1:0] model_mem [`MEMORY_SIZE];
  link_t                    exp_q [4][$];
  link_t                    rx_q [4][$];   // every flit seen on link_out
  int                       rd_ptr [4];
  int                       rx_total [4];
  int                       returned [4];
  int                       credit_back [4];
  int                       injected [4];
  int                       irq_cnt;
  int                       irq_model;
  logic [3:0]               hold;          // withhold credits per output
  logic [7:0]               sent_model;
  logic [6:0]               recv_model;

  manycore_pe #(.ADDRESS(SELF)) dut0 (
    .clock_i      (clock),
    .rst_n_i      (rst_n),
    .link_i       (link_in),
    .link_o       (link_out),
    .credit_i     (credit_in),
    .credit_o     (credit_out),
    .mmio_i       (mmio),
    .mmio_rdata_o (mmio_rdata),
    .irq_o        (irq)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // outputs sampled mid-cycle
  initial begin
    irq_cnt = 0;
    for (int p = 0; p < 4; p++) begin
      rx_total[p]    = 0;
      credit_back[p] = 0;
    end
    forever begin
      @(negedge clock);
      for (int p = 0; p < 4; p++) begin
        if (link_out[p].tx === 1'b1) begin
          rx_q[p].push_back(link_out[p]);
          rx_total[p]++;
        end
        if (credit_out[p] === 1'b1) credit_back[p]++;
      end
      if (irq === 1'b1) irq_cnt++;
    end
  end

  // neighbour side, one credit per received flit after a random delay
  initial begin
    int wait_cyc [4];
    credit_in = '0;
    for (int p = 0; p < 4; p++) begin
      returned[p] = 0;
      wait_cyc[p] = 0;
    end
    forever begin
      @(posedge clock);
      #2;
      for (int p = 0; p < 4; p++) begin
        credit_in[p] = 1'b0;
        if (!hold[p] && rx_total[p] > returned[p]) begin
          if (wait_cyc[p] == 0) begin
            credit_in[p] = 1'b1;
            returned[p]++;
            wait_cyc[p] = $urandom_range(3, 0);
          end else begin
            wait_cyc[p]--;
          end
        end
      end
    end
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(string name, flit_t exp, flit_t act);
    if (act !== exp) fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_link(string name, link_t exp, link_t act);
    if (act !== exp) fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_status(string name, ddma_status_t exp, ddma_status_t act);
    if (act !== exp) fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  // x first, then y
  function automatic int xy_port(node_t d);
    if (d.x > SELF.x) return int'(EAST);
    if (d.x < SELF.x) return int'(WEST);
    if (d.y > SELF.y) return int'(NORTH);
    if (d.y < SELF.y) return int'(SOUTH);
    return int'(LOCAL);
  endfunction

  function automatic node_t random_remote();
    node_t n;
    n = node_t'(8'($urandom));
    while (n == SELF) n = node_t'(8'($urandom));
    return n;
  endfunction

  // all drive tasks start and end 2 ns after a rising edge
  task automatic mmio_write(logic [`ADDR_WIDTH-1:0] addr, logic [`MEMORY_WIDTH-1:0] data);
    mmio = mmio_req_t'{valid: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clock);
    #2;
    mmio = '0;
  endtask

  task automatic mmio_read(logic [`ADDR_WIDTH-1:0] addr, output logic [`MEMORY_WIDTH-1:0] data);
    mmio = mmio_req_t'{valid: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clock);
    #2;
    data = mmio_rdata;   // one cycle after the request
    mmio = '0;
  endtask

  task automatic send_flit(int p, flit_t d);
    int t;
    t = 0;
    while (`BUFFER_DEPTH + credit_back[p] - injected[p] <= 0) begin
      link_in[p].tx = 1'b0;
      @(posedge clock);
      #2;
      t++;
      if (t > TIMEOUT) fail_run($sformatf("no credit came back on input port %0d", p));
    end
    link_in[p] = link_t'{tx: 1'b1, data: d};
    injected[p]++;
    @(posedge clock);
    #2;
    link_in[p].tx = 1'b0;
  endtask

  task automatic send_packet(int p, node_t dest, logic [7:0] raddr, flit_t pay [$]);
    send_flit(p, {8'h00, dest});
    send_flit(p, {8'h00, raddr});
    send_flit(p, {8'h00, 8'(pay.size())});
    foreach (pay[i]) send_flit(p, pay[i]);
  endtask

  task automatic expect_flit(int p, flit_t d);
    exp_q[p].push_back(link_t'{tx: 1'b1, data: d});
  endtask

  task automatic queue_packet(int p, node_t dest, logic [7:0] raddr, flit_t pay [$]);
    expect_flit(p, {8'h00, dest});
    expect_flit(p, {8'h00, raddr});
    expect_flit(p, {8'h00, 8'(pay.size())});
    foreach (pay[i]) expect_flit(p, pay[i]);
  endtask

  task automatic drain_port(string name, int p);
    int    t;
    link_t exp;
    t = 0;
    while (rx_q[p].size() - rd_ptr[p] < exp_q[p].size()) begin
      @(posedge clock);
      #2;
      t++;
      if (t > TIMEOUT) fail_run($sformatf("%s: flits missing on port %0d", name, p));
    end
    while (exp_q[p].size() > 0) begin
      exp = exp_q[p].pop_front();
      check_link(name, exp, rx_q[p][rd_ptr[p]]);
      rd_ptr[p]++;
    end
  endtask

  task automatic wait_irq(string name);
    int t;
    t = 0;
    while (irq_cnt < irq_model) begin
      @(posedge clock);
      #2;
      t++;
      if (t > TIMEOUT) fail_run($sformatf("%s: irq pulse never came", name));
    end
  endtask

  task automatic fill_memory();
    logic [`MEMORY_WIDTH-1:0] d;
    for (int a = 0; a < `MEMORY_SIZE; a++) begin
      d = `MEMORY_WIDTH'($urandom);
      model_mem[a] = d;
      mmio_write(`ADDR_WIDTH'(a), d);
    end
  endtask

  task automatic random_mmio(int n);
    logic [7:0]               a;
    logic [`MEMORY_WIDTH-1:0] d;
    repeat (n) begin
      a = 8'($urandom);
      if ($urandom_range(1, 0) == 1) begin
        d = `MEMORY_WIDTH'($urandom);
        model_mem[a] = d;
        mmio_write({1'b0, a}, d);
      end else begin
        mmio_read({1'b0, a}, d);
        check_word("random_mmio", model_mem[a], d);
      end
    end
  endtask

  task automatic run_descriptor();
    node_t                    dest;
    logic [7:0]               laddr;
    logic [7:0]               raddr;
    logic [7:0]               len;
    logic [`MEMORY_WIDTH-1:0] rd;
    int                       p;
    dest  = random_remote();
    laddr = 8'($urandom);
    raddr = 8'($urandom);
    len   = 8'($urandom_range(8, 1));
    p     = xy_port(dest);
    expect_flit(p, {8'h00, dest});
    expect_flit(p, {8'h00, raddr});
    expect_flit(p, {8'h00, len});
    for (int i = 0; i < len; i++) expect_flit(p, model_mem[8'(laddr + i)]);
    irq_model++;
    mmio_write(9'h100, {8'h00, dest});
    mmio_write(9'h101, {8'h00, laddr});
    mmio_write(9'h102, {8'h00, raddr});
    mmio_write(9'h103, {8'h00, len});   // starts the transfer
    wait_irq("descriptor");
    drain_port("descriptor", p);
    sent_model++;
    mmio_read(9'h100, rd);
    check_status("descriptor_status",
                 ddma_status_t'{busy: 1'b0, sent: sent_model, received: recv_model},
                 ddma_status_t'(rd));
  endtask

  task automatic run_receive();
    int                       p;
    logic [7:0]               raddr;
    flit_t                    pay [$];
    logic [`MEMORY_WIDTH-1:0] rd;
    p     = $urandom_range(3, 0);
    raddr = 8'($urandom);
    repeat ($urandom_range(8, 1)) pay.push_back(flit_t'($urandom));
    foreach (pay[i]) model_mem[8'(raddr + i)] = pay[i];
    irq_model++;
    send_packet(p, SELF, raddr, pay);
    wait_irq("receive");
    recv_model++;
    foreach (pay[i]) begin
      mmio_read({1'b0, 8'(raddr + i)}, rd);
      check_word("receive", model_mem[8'(raddr + i)], rd);
    end
    mmio_read(9'h103, rd);
    check_status("receive_status",
                 ddma_status_t'{busy: 1'b0, sent: sent_model, received: recv_model},
                 ddma_status_t'(rd));
  endtask

  task automatic run_pass_through();
    node_t      dest;
    int         in_p;
    int         out_p;
    logic [7:0] raddr;
    flit_t      pay [$];
    dest  = random_remote();
    in_p  = $urandom_range(3, 0);
    out_p = xy_port(dest);
    raddr = 8'($urandom);
    repeat ($urandom_range(6, 0)) pay.push_back(flit_t'($urandom));
    queue_packet(out_p, dest, raddr, pay);
    send_packet(in_p, dest, raddr, pay);
    drain_port("pass_through", out_p);
  endtask

  task automatic run_backpressure();
    node_t      dest;
    int         in_p;
    int         out_p;
    int         t;
    logic [7:0] raddr;
    flit_t      pay [$];
    dest  = random_remote();
    in_p  = $urandom_range(3, 0);
    out_p = xy_port(dest);
    raddr = 8'($urandom);
    repeat (8) pay.push_back(flit_t'($urandom));
    t = 0;
    while (returned[out_p] < rx_total[out_p]) begin   // router back at full credit
      @(posedge clock);
      #2;
      t++;
      if (t > TIMEOUT) fail_run("credits on the held port never settled");
    end
    hold[out_p] = 1'b1;
    queue_packet(out_p, dest, raddr, pay);
    fork
      send_packet(in_p, dest, raddr, pay);
      begin
        repeat (40) @(posedge clock);
        #2;
        if (rx_q[out_p].size() - rd_ptr[out_p] > `BUFFER_DEPTH)
          fail_run($sformatf("port %0d sent flits with no credit left", out_p));
        hold[out_p] = 1'b0;
      end
    join
    drain_port("backpressure", out_p);
  endtask

  task automatic check_idle();
    for (int p = 0; p < 4; p++) begin
      if (rx_q[p].size() != rd_ptr[p])
        fail_run($sformatf("unexpected flits left port %0d", p));
      // every injected flit has left its input buffer by now
      if (credit_back[p] != injected[p])
        fail_run($sformatf("Mismatch credit_count port %0d: expected %0d, actual %0d",
                           p, injected[p], credit_back[p]));
    end
    if (irq_cnt != irq_model)
      fail_run($sformatf("Mismatch irq_count: expected %0d, actual %0d", irq_model, irq_cnt));
  endtask

  initial begin
    void'($urandom(32'hc06e_33cf));
    rst_n      = 1'b0;
    link_in    = '0;
    mmio       = '0;
    hold       = '0;
    irq_model  = 0;
    sent_model = '0;
    recv_model = '0;
    for (int p = 0; p < 4; p++) begin
      rd_ptr[p]   = 0;
      injected[p] = 0;
    end
    repeat (5) @(posedge clock);
    #2;
    rst_n = 1'b1;

    fill_memory();
    random_mmio(200);
    repeat (4) run_descriptor();
    repeat (4) run_receive();
    repeat (6) run_pass_through();
    run_backpressure();
    check_idle();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/manycore_pe_properties.sv */
`default_nettype none
`include "pe_cfg.svh"

module manycore_pe_properties (
  input logic                 clock_i,
  input logic                 rst_n_i,
  input noc_pkg::link_t [3:0] link_out_i,
  input logic [3:0]           credit_in_i,
  input logic [3:0]           credit_out_i,
  input logic                 irq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CW = $clog2(`BUFFER_DEPTH) + 2;

  logic [3:0] tx_bits;

  always_comb begin
    for (int p = 0; p < 4; p++) tx_bits[p] = link_out_i[p].tx;
  end

  for (genvar p = 0; p < 4; p++) begin : g_link
    logic [CW-1:0] in_flight;   // sent and not yet credited

    always_ff @(posedge clock_i) begin
      if (!rst_n_i) in_flight <= '0;
      else in_flight <= in_flight + CW'(link_out_i[p].tx) - CW'(credit_in_i[p]);
    end

    a_credit: assert property (@(posedge clock_i) disable iff (!rst_n_i)
      link_out_i[p].tx |-> (in_flight < CW'(`BUFFER_DEPTH)))
      else $error("link %0d sent a flit with no credit left", p);
  end

  a_reset_quiet: assert property (@(posedge clock_i)
    !rst_n_i |=> (tx_bits == '0 && credit_out_i == '0 && !irq_i))
    else $error("tx, credit or irq active during reset");

  a_irq_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    irq_i |=> !irq_i)
    else $error("irq held high for more than one cycle");

endmodule

bind manycore_pe manycore_pe_properties props0 (
  .clock_i      (clock_i),
  .rst_n_i      (rst_n_i),
  .link_out_i   (link_o),
  .credit_in_i  (credit_i),
  .credit_out_i (credit_o),
  .irq_i        (irq_o)
);

`default_nettype wire

/* hdl/manycore_pe.sv */
`default_nettype none
`include "pe_cfg.svh"

module manycore_pe #(
  parameter noc_pkg::node_t ADDRESS = '0
) (
  input  logic                     clock_i,
  input  logic                     rst_n_i,
  input  noc_pkg::link_t [3:0]     link_i,
  output noc_pkg::link_t [3:0]     link_o,
  input  logic [3:0]               credit_i,
  output logic [3:0]               credit_o,
  input  pe_pkg::mmio_req_t        mmio_i,
  output logic [`MEMORY_WIDTH-1:0] mmio_rdata_o,
  output logic                     irq_o
);
  import noc_pkg::*;
  import pe_pkg::*;

  link_t [4:0]              rt_in;
  link_t [4:0]              rt_out;
  logic [4:0]               rt_credit_in;
  logic [4:0]               rt_credit_out;
  link_t                    dma_tx;
  logic                     dma_credit;   // ddma consumed a local flit
  mem_req_t                 mem_a;        // ddma side
  mem_req_t                 mem_b;        // mmio side
  logic [`MEMORY_WIDTH-1:0] rdata_a;
  logic [`MEMORY_WIDTH-1:0] rdata_b;
  tcd_t                     tcd;
  logic                     tcd_push;
  ddma_status_t             status;

  // mesh ports 0..3, ddma on LOCAL
  assign rt_in        = {dma_tx, link_i};
  assign rt_credit_in = {dma_credit, credit_i};
  assign link_o       = rt_out[3:0];
  assign credit_o     = rt_credit_out[3:0];

  xy_router #(.ADDRESS(ADDRESS)) router0 (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .in_i     (rt_in),
    .out_o    (rt_out),
    .credit_i (rt_credit_in),
    .credit_o (rt_credit_out)
  );

  ddma ddma0 (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .tcd_i       (tcd),
    .push_i      (tcd_push),
    .rx_i        (rt_out[LOCAL]),
    .tx_o        (dma_tx),
    .credit_i    (rt_credit_out[LOCAL]),
    .credit_o    (dma_credit),
    .mem_o       (mem_a),
    .mem_rdata_i (rdata_a),
    .status_o    (status),
    .irq_o       (irq_o)
  );

  tcd_mmio tcd0 (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .mmio_i      (mmio_i),
    .rdata_o     (mmio_rdata_o),
    .mem_o       (mem_b),
    .mem_rdata_i (rdata_b),
    .tcd_o       (tcd),
    .push_o      (tcd_push),
    .status_i    (status)
  );

  dual_port_ram ram0 (
    .clock_i   (clock_i),
    .a_i       (mem_a),
    .a_rdata_o (rdata_a),
    .b_i       (mem_b),
    .b_rdata_o (rdata_b)
  );

endmodule

`default_nettype wire

/* hdl/dual_port_ram.sv */
`default_nettype none
`include "pe_cfg.svh"

module dual_port_ram (
  input  logic                     clock_i,
  input  pe_pkg::mem_req_t         a_i,
  output logic [`MEMORY_WIDTH-1:0] a_rdata_o,
  input  pe_pkg::mem_req_t         b_i,
  output logic [`MEMORY_WIDTH-1:0] b_rdata_o
);
  import pe_pkg::*;

  logic [`MEMORY_WIDTH-1:0] mem [`MEMORY_SIZE];

  always_ff @(posedge clock_i) begin
    // port A written last, so it wins a same-address collision
    if (b_i.we) mem[b_i.addr] <= b_i.wdata;
    if (a_i.we) mem[a_i.addr] <= a_i.wdata;
  end

  // read data one cycle after the address
  always_ff @(posedge clock_i) begin
    a_rdata_o <= mem[a_i.addr];
    b_rdata_o <= mem[b_i.addr];
  end

endmodule

`default_nettype wire

/* hdl/tcd_mmio.sv */
`default_nettype none
`include "pe_cfg.svh"

module tcd_mmio (
  input  logic                     clock_i,
  input  logic                     rst_n_i,
  input  pe_pkg::mmio_req_t        mmio_i,
  output logic [`MEMORY_WIDTH-1:0] rdata_o,
  output pe_pkg::mem_req_t         mem_o,
  input  logic [`MEMORY_WIDTH-1:0] mem_rdata_i,
  output pe_pkg::tcd_t             tcd_o,
  output logic                     push_o,
  input  pe_pkg::ddma_status_t     status_i
);
  import noc_pkg::*;
  import pe_pkg::*;

  localparam int AW = $clog2(`MEMORY_SIZE);

  logic         is_tcd;
  logic         tcd_wr;
  logic         sel_tcd_q;   // read select, lines up with ram latency
  node_t        dest_q;
  logic [7:0]   local_q;
  logic [7:0]   remote_q;
  logic [7:0]   length_q;
  ddma_status_t status_q;

  assign is_tcd = (mmio_i.addr >= `TCD_CONFIG_ADDR);
  assign tcd_wr = mmio_i.valid && mmio_i.we && is_tcd && (mmio_i.addr[7:2] == '0);

  assign mem_o = '{addr: mmio_i.addr[AW-1:0],
                   we: mmio_i.valid && mmio_i.we && !is_tcd,
                   wdata: mmio_i.wdata};

  assign rdata_o = sel_tcd_q ? status_q : mem_rdata_i;
  assign tcd_o   = '{dest: dest_q, local_addr: local_q, remote_addr: remote_q,
                     length: length_q};

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      push_o    <= 1'b0;
      sel_tcd_q <= 1'b0;
      status_q  <= '0;
      dest_q    <= '0;
      local_q   <= '0;
      remote_q  <= '0;
      length_q  <= '0;
    end else begin
      sel_tcd_q <= is_tcd;
      status_q  <= status_i;
      push_o    <= tcd_wr && (mmio_i.addr[1:0] == 2'd3);   // length write starts it
      if (tcd_wr) begin
        case (mmio_i.addr[1:0])
          2'd0: dest_q <= mmio_i.wdata[7:0];
          2'd1: local_q <= mmio_i.wdata[7:0];
          2'd2: remote_q <= mmio_i.wdata[7:0];
          default: length_q <= mmio_i.wdata[7:0];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ddma.sv */
`default_nettype none
`include "pe_cfg.svh"

module ddma (
  input  logic                     clock_i,
  input  logic                     rst_n_i,
  input  pe_pkg::tcd_t             tcd_i,
  input  logic                     push_i,
  input  noc_pkg::link_t           rx_i,
  output noc_pkg::link_t           tx_o,
  input  logic                     credit_i,
  output logic                     credit_o,
  output pe_pkg::mem_req_t         mem_o,
  input  logic [`MEMORY_WIDTH-1:0] mem_rdata_i,
  output pe_pkg::ddma_status_t     status_o,
  output logic                     irq_o
);
  import noc_pkg::*;
  import pe_pkg::*;

  localparam int CW = $clog2(`BUFFER_DEPTH) + 1;
  localparam int AW = $clog2(`MEMORY_SIZE);

  typedef enum logic [2:0] {S_IDLE, S_HDR, S_ADDR, S_LEN, S_PAY} send_e;
  typedef enum logic [1:0] {R_HDR, R_ADDR, R_LEN, R_PAY} recv_e;

  send_e         s_state;
  recv_e         r_state;
  tcd_t          desc_head;
  tcd_t          cur;
  logic          desc_empty;
  logic          desc_pop;
  logic [CW-1:0] credits;
  logic [7:0]    s_left;
  logic [7:0]    s_off;
  logic          rd_pend;
  logic          can_send;
  logic          rd_issue;
  logic          tx_fire;
  logic          send_done;
  logic [7:0]    r_base;
  logic [7:0]    r_left;
  logic [7:0]    r_off;
  logic          rx_wr;
  logic          recv_done;
  logic          pend_tx;
  logic          pend_rx;
  logic [7:0]    sent_cnt;
  logic [6:0]    recv_cnt;

  flit_fifo #(.payload_t(tcd_t), .DEPTH(`BUFFER_DEPTH)) u_desc (
    .clock_i (clock_i),
    .rst_n_i (rst_n_i),
    .push_i  (push_i),
    .data_i  (tcd_i),
    .pop_i   (desc_pop),
    .data_o  (desc_head),
    .empty_o (desc_empty),
    .full_o  ()
  );

  assign desc_pop  = (s_state == S_IDLE) && !desc_empty;
  assign can_send  = (credits != '0);
  assign rx_wr     = rx_i.tx && (r_state == R_PAY);
  assign rd_issue  = (s_state == S_PAY) && !rd_pend && can_send && !rx_wr;
  assign tx_fire   = ((s_state inside {S_HDR, S_ADDR, S_LEN}) && can_send) ||
                     ((s_state == S_PAY) && rd_pend);
  assign send_done = ((s_state == S_LEN) && can_send && cur.length == 8'd0) ||
                     ((s_state == S_PAY) && rd_pend && s_left == 8'd1);
  assign recv_done = rx_i.tx && (((r_state == R_LEN) && rx_i.data[7:0] == 8'd0) ||
                                 ((r_state == R_PAY) && r_left == 8'd1));

  // receive writes take port A first, send reads wait
  always_comb begin
    if (rx_wr) mem_o = '{addr: AW'(r_base + r_off), we: 1'b1, wdata: rx_i.data};
    else mem_o = '{addr: AW'(cur.local_addr + s_off), we: 1'b0, wdata: '0};
  end

  assign status_o = '{busy: (s_state != S_IDLE) || !desc_empty || (r_state != R_HDR),
                      sent: sent_cnt, received: recv_cnt};

  always_ff @(posedge clock_i) begin
    if (desc_pop) cur <= desc_head;
  end

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      s_state <= S_IDLE;
      credits <= CW'(`BUFFER_DEPTH);
      tx_o    <= '0;
      rd_pend <= 1'b0;
      s_left  <= '0;
      s_off   <= '0;
    end else begin
      credits  <= credits - CW'(tx_fire) + CW'(credit_i);
      tx_o.tx  <= 1'b0;
      case (s_state)
        S_IDLE: if (desc_pop) s_state <= S_HDR;
        S_HDR: if (can_send) begin
          tx_o    <= '{tx: 1'b1, data: {8'h00, cur.dest}};
          s_state <= S_ADDR;
        end
        S_ADDR: if (can_send) begin
          tx_o    <= '{tx: 1'b1, data: {8'h00, cur.remote_addr}};
          s_state <= S_LEN;
        end
        S_LEN: if (can_send) begin
          tx_o    <= '{tx: 1'b1, data: {8'h00, cur.length}};
          s_left  <= cur.length;
          s_off   <= '0;
          s_state <= (cur.length == 8'd0) ? S_IDLE : S_PAY;
        end
        default: begin
          if (rd_issue) rd_pend <= 1'b1;
          if (rd_pend) begin   // word read last cycle is on mem_rdata_i now
            tx_o    <= '{tx: 1'b1, data: mem_rdata_i};
            rd_pend <= 1'b0;
            s_off   <= s_off + 8'd1;
            s_left  <= s_left - 8'd1;
            if (s_left == 8'd1) s_state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      r_state  <= R_HDR;
      r_base   <= '0;
      r_left   <= '0;
      r_off    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= rx_i.tx;   // no rx buffer, every flit is consumed at once
      if (rx_i.tx) begin
        case (r_state)
          R_HDR: r_state <= R_ADDR;
          R_ADDR: begin
            r_base  <= rx_i.data[7:0];
            r_state <= R_LEN;
          end
          R_LEN: begin
            r_left  <= rx_i.data[7:0];
            r_off   <= '0;
            r_state <= (rx_i.data[7:0] == 8'd0) ? R_HDR : R_PAY;
          end
          default: begin
            r_off  <= r_off + 8'd1;
            r_left <= r_left - 8'd1;
            if (r_left == 8'd1) r_state <= R_HDR;
          end
        endcase
      end
    end
  end

  // completions queue up so that irq stays a one-cycle pulse
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      irq_o    <= 1'b0;
      pend_tx  <= 1'b0;
      pend_rx  <= 1'b0;
      sent_cnt <= '0;
      recv_cnt <= '0;
    end else begin
      irq_o    <= 1'b0;
      sent_cnt <= sent_cnt + 8'(send_done);
      recv_cnt <= recv_cnt + 7'(recv_done);
      if (!irq_o && pend_tx) begin
        irq_o   <= 1'b1;
        pend_tx <= 1'b0;
      end else if (!irq_o && pend_rx) begin
        irq_o   <= 1'b1;
        pend_rx <= 1'b0;
      end
      if (send_done) pend_tx <= 1'b1;
      if (recv_done) pend_rx <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/xy_router.sv */
`default_nettype none
`include "pe_cfg.svh"

module xy_router #(
  parameter noc_pkg::node_t ADDRESS = '0
) (
  input  logic                 clock_i,
  input  logic                 rst_n_i,
  input  noc_pkg::link_t [4:0] in_i,
  output noc_pkg::link_t [4:0] out_o,
  input  logic [4:0]           credit_i,
  output logic [4:0]           credit_o
);
  import noc_pkg::*;

  localparam int CW = $clog2(`BUFFER_DEPTH) + 1;

  typedef enum logic [1:0] {PH_HDR, PH_ADDR, PH_LEN, PH_PAY} phase_e;

  flit_t      head [5];
  logic [4:0] empty;
  logic [4:0] last;
  logic [4:0] pop;
  logic [2:0] req_port [5];
  logic [2:0] sel [5];
  logic [4:0] send;

  // x first, then y, then deliver
  function automatic logic [2:0] xy_route(flit_t hdr);
    node_t dst;
    dst = hdr[7:0];
    if (dst.x > ADDRESS.x) return EAST;
    if (dst.x < ADDRESS.x) return WEST;
    if (dst.y > ADDRESS.y) return NORTH;
    if (dst.y < ADDRESS.y) return SOUTH;
    return LOCAL;
  endfunction

  for (genvar i = 0; i < 5; i++) begin : g_in
    phase_e     phase;
    logic [7:0] remain;
    logic [2:0] route_q;   // output held for the rest of the packet

    flit_fifo #(.payload_t(flit_t), .DEPTH(`BUFFER_DEPTH)) u_buf (
      .clock_i (clock_i),
      .rst_n_i (rst_n_i),
      .push_i  (in_i[i].tx),
      .data_i  (in_i[i].data),
      .pop_i   (pop[i]),
      .data_o  (head[i]),
      .empty_o (empty[i]),
      .full_o  ()
    );

    assign req_port[i] = (phase == PH_HDR) ? xy_route(head[i]) : route_q;
    assign last[i] = (phase == PH_LEN && head[i][7:0] == 8'd0) ||
                     (phase == PH_PAY && remain == 8'd1);

    always_ff @(posedge clock_i) begin
      if (!rst_n_i) begin
        phase   <= PH_HDR;
        remain  <= '0;
        route_q <= LOCAL;
      end else if (pop[i]) begin
        case (phase)
          PH_HDR: begin
            route_q <= req_port[i];
            phase   <= PH_ADDR;
          end
          PH_ADDR: phase <= PH_LEN;
          PH_LEN: begin
            remain <= head[i][7:0];
            phase  <= (head[i][7:0] == 8'd0) ? PH_HDR : PH_PAY;
          end
          default: begin
            remain <= remain - 8'd1;
            if (remain == 8'd1) phase <= PH_HDR;
          end
        endcase
      end
    end
  end

  for (genvar o = 0; o < 5; o++) begin : g_out
    logic          lock;
    logic [2:0]    owner;
    logic [2:0]    rr;      // next input to favour
    logic [2:0]    pick;
    logic          found;
    logic [CW-1:0] credits;
    link_t         out_q;

    always_comb begin
      int idx;
      pick  = rr;
      found = 1'b0;
      for (int k = 0; k < 5; k++) begin
        idx = (int'(rr) + k) % 5;
        if (!found && !empty[idx] && req_port[idx] == 3'(o)) begin
          found = 1'b1;
          pick  = 3'(idx);
        end
      end
    end

    assign sel[o]  = lock ? owner : pick;
    assign send[o] = (lock ? !empty[owner] : found) && (credits != '0);
    assign out_o[o] = out_q;

    always_ff @(posedge clock_i) begin
      if (!rst_n_i) begin
        lock    <= 1'b0;
        owner   <= '0;
        rr      <= '0;
        credits <= CW'(`BUFFER_DEPTH);
        out_q   <= '0;
      end else begin
        credits    <= credits - CW'(send[o]) + CW'(credit_i[o]);
        out_q.tx   <= send[o];
        out_q.data <= head[sel[o]];
        if (send[o]) begin
          if (last[sel[o]]) begin
            lock <= 1'b0;
            rr   <= (sel[o] == 3'd4) ? 3'd0 : sel[o] + 3'd1;
          end else begin
            lock  <= 1'b1;
            owner <= sel[o];
          end
        end
      end
    end
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < 5; o++) begin
      if (send[o]) pop[sel[o]] = 1'b1;
    end
  end

  // one credit back per flit leaving a buffer
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) credit_o <= '0;
    else credit_o <= pop;
  end

endmodule

`default_nettype wire

/* hdl/flit_fifo.sv */
`default_nettype none
`include "pe_cfg.svh"

module flit_fifo #(
  parameter type payload_t = logic [`FLIT_WIDTH-1:0],
  parameter int  DEPTH     = `BUFFER_DEPTH
) (
  input  logic     clock_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      slots [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          do_push;
  logic          do_pop;

  function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o  = (count == (PW+1)'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;   // push into a full fifo is dropped
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = slots[rd_ptr];       // show-ahead

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
    end
  end

  always_ff @(posedge clock_i) begin
    if (do_push) slots[wr_ptr] <= data_i;
  end

endmodule

`default_nettype wire

/* hdl/pe_pkg.sv */
`default_nettype none
`include "pe_cfg.svh"

package pe_pkg;

  typedef struct packed {
    logic [$clog2(`MEMORY_SIZE)-1:0] addr;
    logic                            we;
    logic [`MEMORY_WIDTH-1:0]        wdata;
  } mem_req_t;

  typedef struct packed {
    logic                     valid;
    logic                     we;
    logic [`ADDR_WIDTH-1:0]   addr;
    logic [`MEMORY_WIDTH-1:0] wdata;
  } mmio_req_t;

  // transfer descriptor as assembled from the tcd registers
  typedef struct packed {
    noc_pkg::node_t dest;
    logic [7:0]     local_addr;
    logic [7:0]     remote_addr;
    logic [7:0]     length;      // payload words
  } tcd_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] sent;
    logic [6:0] received;
  } ddma_status_t;

endpackage

`default_nettype wire

/* hdl/noc_pkg.sv */
`default_nettype none
`include "pe_cfg.svh"

package noc_pkg;

  typedef logic [`FLIT_WIDTH-1:0] flit_t;

  // mesh coordinate, sits in the low byte of a header flit
  typedef struct packed {
    logic [3:0] x;
    logic [3:0] y;
  } node_t;

  // index order of the router ports
  typedef enum logic [2:0] {
    EAST  = 3'd0,
    WEST  = 3'd1,
    NORTH = 3'd2,
    SOUTH = 3'd3,
    LOCAL = 3'd4
  } port_e;

  typedef struct packed {
    logic  tx;    // one cycle per flit
    flit_t data;
  } link_t;

endpackage

`default_nettype wire

/* hdl/pe_cfg.svh */
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// network
`define FLIT_WIDTH 16

// one payload flit carries exactly one memory word
`define MEMORY_WIDTH 16
`define MEMORY_SIZE 256

// mmio bus seen by the core
`define ADDR_WIDTH 9

// router input buffers, also the initial credit count per output
`define BUFFER_DEPTH 4

// tcd register window, everything below is data memory
`define TCD_CONFIG_ADDR 'h100

`endif
